// File: design/ahb_lite_pkg.sv
//////////////////////////////////////////////////
// AHB-Lite encodings for a 32-bit little-endian bus
// Only single transfers, no bursts and no locking
// Lane view assumes byte 0 sits on HDATA[7:0]
//////////////////////////////////////////////////

package ahb_lite_pkg;

  // Transfer type, only the two used by a single-transfer master
  typedef logic [1:0] htrans_t;
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;

  // Transfer size
  typedef logic [2:0] hsize_t;
  localparam hsize_t HSIZE_BYTE = 3'b000;
  localparam hsize_t HSIZE_HALF = 3'b001;
  localparam hsize_t HSIZE_WORD = 3'b010;

  // Data, privileged, not bufferable, not cacheable
  localparam logic [3:0] HPROT_DEBUG_DATA = 4'b0011;

  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // One bus word seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0]  byte_lane;
    logic [1:0][15:0] half_lane;
  } lane_word_u;

endpackage

// File: design/dbg_req_pkg.sv
//////////////////////////////////////////////////
// Debug-port request and response formats
// Addresses must be aligned to the access size
// Credit depths fix the queue sizes in all stages
//////////////////////////////////////////////////

package dbg_req_pkg;

  // Access size of a debug request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } dbg_size_t;

  // Request from the debug controller
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
    dbg_size_t   size;
  } dbg_req_t;

  // Queued command, already in bus format
  typedef struct packed {
    logic [31:0] haddr;
    logic [31:0] hwdata;
    logic        hwrite;
    logic [2:0]  hsize;
    dbg_size_t   size;
  } bus_cmd_t;

  // Raw bus result plus what is needed to pick the lane
  typedef struct packed {
    logic [31:0] hrdata;
    logic [1:0]  lane;
    dbg_size_t   size;
    logic        err;
  } bus_rsp_t;

  // Response to the debug controller
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } dbg_rsp_t;

  // Credit depths
  localparam int REQ_CREDITS = 2;
  localparam int RSP_CREDITS = 2;
  localparam int CMD_CREDITS = 1;

endpackage

// File: design/dbg_req_stage.sv
//////////////////////////////////////////////////
// Request stage of the debug AHB bridge
// Requester must hold a credit for every req_valid
// Write data is replicated to all byte lanes here
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_req_stage (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  logic                  req_valid,
  input  dbg_req_pkg::dbg_req_t req,
  input  logic                  cmd_pop,
  output logic                  cmd_valid,
  output dbg_req_pkg::bus_cmd_t cmd
);

  import dbg_req_pkg::*;
  import ahb_lite_pkg::*;

  localparam int PTR_W = $clog2(REQ_CREDITS);
  localparam int CNT_W = $clog2(REQ_CREDITS + 1);

  bus_cmd_t           q_mem [REQ_CREDITS];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   q_count;
  lane_word_u         wd_lanes;
  logic [31:0]        wdata_rep;
  hsize_t             hsize_enc;
  bus_cmd_t           new_cmd;

  //////////////////////////////////////////////////
  // Request to bus command
  //////////////////////////////////////////////////

  assign wd_lanes = req.wdata;

  always_comb begin
    case (req.size)
      SIZE_BYTE: begin
        hsize_enc = HSIZE_BYTE;
        // Low byte on every lane
        wdata_rep = {4{wd_lanes.byte_lane[0]}};
      end
      SIZE_HALF: begin
        hsize_enc = HSIZE_HALF;
        wdata_rep = {2{wd_lanes.half_lane[0]}};
      end
      default: begin
        hsize_enc = HSIZE_WORD;
        wdata_rep = req.wdata;
      end
    endcase
  end

  assign new_cmd = '{haddr: req.addr, hwdata: wdata_rep, hwrite: req.write,
                     hsize: hsize_enc, size: req.size};

  //////////////////////////////////////////////////
  // Two-entry circular queue
  //////////////////////////////////////////////////

  // Storage, room is guaranteed by the credits
  always_ff @(posedge HCLK) begin
    if (req_valid) begin
      q_mem[wr_ptr] <= new_cmd;
    end
  end

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (cmd_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({req_valid, cmd_pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  // Head of queue goes straight to the bus stage
  assign cmd_valid = (q_count != '0);
  assign cmd       = q_mem[rd_ptr];

endmodule

// File: design/ahb_issue_stage.sv
//////////////////////////////////////////////////
// Bus stage, one AHB-Lite single transfer at a time
// Address phase is one cycle, HREADY high in idle
// A transfer starts only with a stage-3 credit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_issue_stage (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  logic                  cmd_valid,
  input  dbg_req_pkg::bus_cmd_t cmd,
  output logic                  cmd_pop,
  input  logic                  bres_credit,
  output logic                  bres_valid,
  output dbg_req_pkg::bus_rsp_t bres,
  output logic [31:0]           HADDR,
  output logic [31:0]           HWDATA,
  output logic                  HWRITE,
  output ahb_lite_pkg::hsize_t  HSIZE,
  output ahb_lite_pkg::htrans_t HTRANS,
  input  logic [31:0]           HRDATA,
  input  logic                  HREADY,
  input  logic                  HRESP
);

  import dbg_req_pkg::*;
  import ahb_lite_pkg::*;

  localparam int CRD_W = $clog2(CMD_CREDITS + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t           state;
  logic [CRD_W-1:0] credit_cnt;
  dbg_size_t        size_q;
  logic             issue;

  // Start when a command waits and stage 3 has room
  assign issue = (state == ST_IDLE) && cmd_valid && (credit_cnt != '0);

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state   <= ST_IDLE;
      HTRANS  <= HTRANS_IDLE;
      cmd_pop <= 1'b0;
    end else begin
      // Pop pulse rises together with NONSEQ
      cmd_pop <= issue;
      case (state)
        ST_IDLE: begin
          if (issue) begin
            HTRANS <= HTRANS_NONSEQ;
            state  <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          HTRANS <= HTRANS_IDLE;
          state  <= ST_DATA;
        end
        ST_DATA: begin
          // Wait states stretch this phase
          if (HREADY) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          HTRANS <= HTRANS_IDLE;
          state  <= ST_IDLE;
        end
      endcase
    end
  end

  // Credits toward stage 3
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      credit_cnt <= CRD_W'(CMD_CREDITS);
    end else begin
      case ({issue, bres_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Address, control and write data held until the next issue
  always_ff @(posedge HCLK) begin
    if (issue) begin
      HADDR  <= cmd.haddr;
      HWDATA <= cmd.hwdata;
      HWRITE <= cmd.hwrite;
      HSIZE  <= cmd.hsize;
      size_q <= cmd.size;
    end
  end

  //////////////////////////////////////////////////
  // Result toward stage 3
  //////////////////////////////////////////////////

  assign bres_valid = (state == ST_DATA) && HREADY;
  assign bres = '{hrdata: HRDATA, lane: HADDR[1:0], size: size_q, err: HRESP};

endmodule

// File: design/dbg_rsp_stage.sv
//////////////////////////////////////////////////
// Response stage, lane extraction and credit output
// Reads are zero-extended from their lane
// Consumer returns one rsp_credit per response
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_rsp_stage (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  logic                  bres_valid,
  input  dbg_req_pkg::bus_rsp_t bres,
  output logic                  bres_credit,
  input  logic                  rsp_credit,
  output logic                  rsp_valid,
  output dbg_req_pkg::dbg_rsp_t rsp
);

  import dbg_req_pkg::*;
  import ahb_lite_pkg::*;

  localparam int QDEPTH = CMD_CREDITS + 1;
  localparam int PTR_W  = $clog2(QDEPTH);
  localparam int CNT_W  = $clog2(QDEPTH + 1);
  localparam int RCRD_W = $clog2(RSP_CREDITS + 1);

  dbg_rsp_t          q_mem [QDEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  q_count;
  logic [RCRD_W-1:0] rsp_cnt;
  lane_word_u        rd_lanes;
  logic [31:0]       rdata_ext;
  logic              send;

  //////////////////////////////////////////////////
  // Read lane extraction
  //////////////////////////////////////////////////

  assign rd_lanes = bres.hrdata;

  always_comb begin
    case (bres.size)
      SIZE_BYTE: rdata_ext = {24'h0, rd_lanes.byte_lane[bres.lane]};
      SIZE_HALF: rdata_ext = {16'h0, rd_lanes.half_lane[bres.lane[1]]};
      default:   rdata_ext = bres.hrdata;
    endcase
  end

  //////////////////////////////////////////////////
  // Response queue and output
  //////////////////////////////////////////////////

  // One response per cycle while the consumer has room
  assign send        = (q_count != '0) && (rsp_cnt != '0);
  assign bres_credit = send;

  always_ff @(posedge HCLK) begin
    if (bres_valid) begin
      q_mem[wr_ptr] <= '{rdata: rdata_ext, err: bres.err};
    end
    if (send) begin
      rsp <= q_mem[rd_ptr];
    end
  end

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      q_count   <= '0;
      rsp_cnt   <= RCRD_W'(RSP_CREDITS);
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= send;
      if (bres_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({bres_valid, send})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      // Consumer credits
      case ({send, rsp_credit})
        2'b10:   rsp_cnt <= rsp_cnt - 1'b1;
        2'b01:   rsp_cnt <= rsp_cnt + 1'b1;
        default: rsp_cnt <= rsp_cnt;
      endcase
    end
  end

endmodule

// File: design/dbg_ahb_bridge.sv
//////////////////////////////////////////////////
// Debug port to AHB-Lite master, three-stage pipe
// Credit flow control on request and response side
// Zero wait states give rsp_valid four edges later
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_ahb_bridge (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  // Debug request side
  input  logic                  req_valid,
  input  dbg_req_pkg::dbg_req_t req,
  output logic                  req_credit,
  // Debug response side
  output logic                  rsp_valid,
  output dbg_req_pkg::dbg_rsp_t rsp,
  input  logic                  rsp_credit,
  // AHB-Lite master
  output logic                  HSEL,
  output logic [31:0]           HADDR,
  output logic [31:0]           HWDATA,
  output logic                  HWRITE,
  output ahb_lite_pkg::hsize_t  HSIZE,
  output logic [2:0]            HBURST,
  output logic [3:0]            HPROT,
  output ahb_lite_pkg::htrans_t HTRANS,
  output logic                  HMASTLOCK,
  input  logic [31:0]           HRDATA,
  input  logic                  HREADY,
  input  logic                  HRESP
);

  import dbg_req_pkg::*;
  import ahb_lite_pkg::*;

  logic     cmd_valid;
  logic     cmd_pop;
  bus_cmd_t cmd;
  logic     bres_valid;
  logic     bres_credit;
  bus_rsp_t bres;

  // Every popped queue entry frees a requester credit
  assign req_credit = cmd_pop;

  // Fixed control, single privileged data accesses
  assign HSEL      = 1'b1;
  assign HMASTLOCK = 1'b0;
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_DEBUG_DATA;

  dbg_req_stage i_dbg_req_stage (
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .req_valid (req_valid),
    .req       (req),
    .cmd_pop   (cmd_pop),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

  ahb_issue_stage i_ahb_issue_stage (
    .HCLK        (HCLK),
    .ahb_rstn    (ahb_rstn),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_pop     (cmd_pop),
    .bres_credit (bres_credit),
    .bres_valid  (bres_valid),
    .bres        (bres),
    .HADDR       (HADDR),
    .HWDATA      (HWDATA),
    .HWRITE      (HWRITE),
    .HSIZE       (HSIZE),
    .HTRANS      (HTRANS),
    .HRDATA      (HRDATA),
    .HREADY      (HREADY),
    .HRESP       (HRESP)
  );

  dbg_rsp_stage i_dbg_rsp_stage (
    .HCLK        (HCLK),
    .ahb_rstn    (ahb_rstn),
    .bres_valid  (bres_valid),
    .bres        (bres),
    .bres_credit (bres_credit),
    .rsp_credit  (rsp_credit),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

endmodule

// File: sim/ahb_mem_model.sv
//////////////////////////////////////////////////
// AHB-Lite slave model with 256 words of memory
// Address bits above [9:2] alias, no bounds check
// Wait states equal HADDR[5:4], error at 0x800 up
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_mem_model (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  logic                  HSEL,
  input  logic [31:0]           HADDR,
  input  logic [31:0]           HWDATA,
  input  logic                  HWRITE,
  input  ahb_lite_pkg::hsize_t  HSIZE,
  input  ahb_lite_pkg::htrans_t HTRANS,
  output logic [31:0]           HRDATA,
  output logic                  HREADY,
  output logic                  HRESP
);

  import ahb_lite_pkg::*;

  logic [31:0] mem [256];
  logic        active;
  logic [1:0]  wait_cnt;
  logic [31:0] ph_addr;
  logic        ph_write;
  hsize_t      ph_size;
  logic        ph_err;
  logic        accept;
  logic [3:0]  be;
  lane_word_u  wr_word;
  lane_word_u  merged;

  // Fill pattern built from the full word index, one rule per lane
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'h5a, 8'(i), 8'(i) + 8'h3c, ~8'(i)};
    end
  end

  // Address phase seen while the bus is ready
  assign accept = HSEL && HTRANS[1] && HREADY;

  //////////////////////////////////////////////////
  // Byte-lane write merge
  //////////////////////////////////////////////////

  always_comb begin
    case (ph_size)
      HSIZE_BYTE: be = 4'b0001 << ph_addr[1:0];
      HSIZE_HALF: be = ph_addr[1] ? 4'b1100 : 4'b0011;
      default:    be = 4'b1111;
    endcase
    wr_word = HWDATA;
    merged  = mem[ph_addr[9:2]];
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged.byte_lane[i] = wr_word.byte_lane[i];
      end
    end
  end

  // Write commits at the end of the data phase, never on error
  always @(posedge HCLK) begin
    if (active && HREADY && ph_write && !ph_err) begin
      mem[ph_addr[9:2]] <= merged;
    end
  end

  //////////////////////////////////////////////////
  // Data phase sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      active   <= 1'b0;
      wait_cnt <= 2'd0;
      ph_addr  <= '0;
      ph_write <= 1'b0;
      ph_size  <= HSIZE_BYTE;
      ph_err   <= 1'b0;
      HREADY   <= 1'b1;
      HRESP    <= 1'b0;
      HRDATA   <= '0;
    end else begin
      if (active) begin
        if (HREADY) begin
          active <= 1'b0;
          HRESP  <= 1'b0;
        end else if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
          // Last wait state, next cycle ends or starts the error
          if (wait_cnt == 2'd1) begin
            HREADY <= !ph_err;
            HRESP  <= ph_err;
            HRDATA <= mem[ph_addr[9:2]];
          end
        end else begin
          // Second cycle of the error response
          HREADY <= 1'b1;
        end
      end
      if (accept) begin
        active   <= 1'b1;
        ph_addr  <= HADDR;
        ph_write <= HWRITE;
        ph_size  <= HSIZE;
        ph_err   <= (HADDR >= 32'h800);
        wait_cnt <= HADDR[5:4];
        HREADY   <= (HADDR[5:4] == 2'd0) && (HADDR < 32'h800);
        HRESP    <= (HADDR[5:4] == 2'd0) && (HADDR >= 32'h800);
        HRDATA   <= mem[HADDR[9:2]];
      end
    end
  end

endmodule

// File: sim/tb_dbg_ahb_bridge.sv
//////////////////////////////////////////////////
// Directed testbench for the debug AHB bridge
// Reference bytes mirror the memory model fill
// Addresses 0x400 to 0x7ff alias the low 1 KiB
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dbg_ahb_bridge;

  import dbg_req_pkg::*;
  import ahb_lite_pkg::*;

  localparam int WAIT_LIMIT = 300;

  // Expected response
  typedef struct packed {
    logic        is_read;
    logic        err;
    logic [31:0] rdata;
  } exp_rsp_t;

  // Expected bus transfer
  typedef struct packed {
    logic [31:0] haddr;
    logic        write;
    logic [2:0]  hsize;
    logic [31:0] hwdata;
  } exp_bus_t;

  logic        HCLK;
  logic        ahb_rstn;
  logic        req_valid;
  dbg_req_t    req;
  logic        req_credit;
  logic        rsp_valid;
  dbg_rsp_t    rsp;
  logic        rsp_credit;
  logic        HSEL;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  hsize_t      HSIZE;
  logic [2:0]  HBURST;
  logic [3:0]  HPROT;
  htrans_t     HTRANS;
  logic        HMASTLOCK;
  logic [31:0] HRDATA;
  logic        HREADY;
  logic        HRESP;

  logic [7:0]  ref_mem [1024];
  exp_rsp_t    rsp_q [$];
  exp_bus_t    bus_q [$];
  exp_bus_t    data_chk;
  logic        data_due;
  logic        hold_credit;
  int          credits;
  int          owed;
  int          cycle;
  int          last_rsp_cycle;
  int          last_credit_cycle;
  int          rsp_seen;
  int          wr_seen;
  int          n_checks;
  int          n_errors;

  dbg_ahb_bridge i_dbg_ahb_bridge (.*);
  ahb_mem_model  i_ahb_mem_model (.*);

  always #5 HCLK = ~HCLK;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Same fill as the memory model, from the byte address
  function automatic logic [7:0] fill_byte(input logic [9:0] a);
    logic [7:0] w;
    w = a[9:2];
    case (a[1:0])
      2'd0:    return ~w;
      2'd1:    return w + 8'h3c;
      2'd2:    return w;
      default: return w ^ 8'h5a;
    endcase
  endfunction

  function automatic logic [31:0] align_addr(input logic [31:0] raw, input dbg_size_t size);
    return raw & ~((32'd1 << size) - 32'd1);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    n_errors++;
    $display("Timeout while waiting for %s", what);
    end_run();
  endtask

  // One clock, then monitor the bus and the response port
  task automatic tick();
    exp_rsp_t e;
    @(posedge HCLK);
    #1;
    cycle++;
    req_valid  = 1'b0;
    rsp_credit = 1'b0;
    if (req_credit) begin
      credits++;
      last_credit_cycle = cycle;
    end
    // First data phase cycle of the previous NONSEQ
    if (data_due) begin
      data_due = 1'b0;
      if (data_chk.write) begin
        check_val("HWDATA", HWDATA, data_chk.hwdata);
        wr_seen++;
      end
    end
    if (HTRANS == HTRANS_NONSEQ) begin
      assert (bus_q.size() != 0) else begin
        n_errors++;
        $display("Bus transfer started with no request pending");
      end
      if (bus_q.size() != 0) begin
        data_chk = bus_q.pop_front();
        check_val("HADDR", HADDR, data_chk.haddr);
        check_val("HSIZE", 32'(HSIZE), 32'(data_chk.hsize));
        check_val("HWRITE", 32'(HWRITE), 32'(data_chk.write));
        data_due = 1'b1;
      end
    end
    if (rsp_valid) begin
      rsp_seen++;
      last_rsp_cycle = cycle;
      owed++;
      assert (rsp_q.size() != 0) else begin
        n_errors++;
        $display("Response arrived with no request outstanding");
      end
      if (rsp_q.size() != 0) begin
        e = rsp_q.pop_front();
        check_val("rsp.err", 32'(rsp.err), 32'(e.err));
        if (e.is_read && !e.err) begin
          check_val("rsp.rdata", rsp.rdata, e.rdata);
        end
      end
    end
    // Consumer hands back one credit per cycle
    if (!hold_credit && owed > 0) begin
      rsp_credit = 1'b1;
      owed--;
    end
  endtask

  // Waits for a credit, then presents one request for one cycle
  task automatic send_req(input logic write, input dbg_size_t size, input logic [31:0] addr,
                          input logic [31:0] wdata);
    exp_rsp_t e;
    exp_bus_t b;
    int       waited;
    int       nbytes;
    waited = 0;
    while (credits == 0) begin
      if (waited == WAIT_LIMIT) timeout_abort("a request credit");
      tick();
      waited++;
    end
    nbytes  = 1 << int'(size);
    b.haddr = addr;
    b.write = write;
    case (size)
      SIZE_BYTE: b.hsize = 3'd0;
      SIZE_HALF: b.hsize = 3'd1;
      default:   b.hsize = 3'd2;
    endcase
    // AHB write data repeats the narrow value on every lane
    case (size)
      SIZE_BYTE: b.hwdata = {4{wdata[7:0]}};
      SIZE_HALF: b.hwdata = {2{wdata[15:0]}};
      default:   b.hwdata = wdata;
    endcase
    e.is_read = !write;
    e.err     = (addr >= 32'h800);
    e.rdata   = '0;
    for (int i = 0; i < nbytes; i++) begin
      if (write && !e.err) ref_mem[addr[9:0] + 10'(i)] = wdata[8*i +: 8];
      e.rdata[8*i +: 8] = ref_mem[addr[9:0] + 10'(i)];
    end
    req_valid = 1'b1;
    req       = '{addr: addr, wdata: wdata, write: write, size: size};
    credits--;
    rsp_q.push_back(e);
    bus_q.push_back(b);
    tick();
  endtask

  task automatic send_random(input logic [1:0] ws);
    dbg_size_t   size;
    logic [31:0] addr;
    size = dbg_size_t'($urandom_range(2, 0));
    addr = align_addr(($urandom() & 32'h7cf) | {26'h0, ws, 4'h0}, size);
    send_req($urandom_range(1, 0) == 1, size, addr, $urandom());
  endtask

  // Until every response and every returned credit is through
  task automatic drain();
    int waited;
    waited = 0;
    while (rsp_q.size() != 0 || owed != 0 || rsp_credit) begin
      if (waited == WAIT_LIMIT) timeout_abort("outstanding responses");
      tick();
      waited++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int acc;
    int base;
    int waited;
    check_val("HTRANS", 32'(HTRANS), 32'(2'b00));
    check_val("rsp_valid", 32'(rsp_valid), 32'd0);
    check_val("req_credit", 32'(req_credit), 32'd0);
    check_val("HSEL", 32'(HSEL), 32'd1);
    check_val("HMASTLOCK", 32'(HMASTLOCK), 32'd0);
    check_val("HBURST", 32'(HBURST), 32'd0);
    check_val("HPROT", 32'(HPROT), 32'h3);
    base = rsp_seen;
    send_req(1'b0, SIZE_WORD, 32'h0000_0004, '0);
    acc    = cycle;
    waited = 0;
    while (rsp_seen == base) begin
      if (waited == WAIT_LIMIT) timeout_abort("the first response");
      tick();
      waited++;
    end
    check_val("first response latency", 32'(last_rsp_cycle - acc), 32'd4);
    drain();
  endtask

  task automatic test_round_trip();
    dbg_size_t   size;
    logic [31:0] addr;
    for (int i = 0; i < 9; i++) begin
      size = dbg_size_t'(i % 3);
      addr = align_addr($urandom_range(32'h7ff, 0), size);
      send_req(1'b1, size, addr, $urandom());
      send_req(1'b0, size, addr, '0);
      // Whole word shows the merge with untouched lanes
      send_req(1'b0, SIZE_WORD, addr & ~32'h3, '0);
    end
    drain();
  endtask

  task automatic test_write_lanes();
    int start;
    start = wr_seen;
    for (int l = 0; l < 4; l++) begin
      send_req(1'b1, SIZE_BYTE, 32'h100 + 32'(l), {24'habcdef, 8'(8'h21 + l)});
    end
    send_req(1'b1, SIZE_HALF, 32'h204, 32'h5a5a_1234);
    send_req(1'b1, SIZE_HALF, 32'h206, 32'h0f0f_abcd);
    send_req(1'b1, SIZE_WORD, 32'h208, 32'hdead_beef);
    send_req(1'b0, SIZE_WORD, 32'h100, '0);
    send_req(1'b0, SIZE_WORD, 32'h204, '0);
    drain();
    check_val("write data phases seen", 32'(wr_seen - start), 32'd7);
  endtask

  task automatic test_bus_error();
    send_req(1'b0, SIZE_WORD, 32'h800, '0);
    send_req(1'b1, SIZE_HALF, 32'h912, 32'hbeef);
    // Three wait states before the error
    send_req(1'b0, SIZE_BYTE, 32'hffff_fff3, '0);
    send_req(1'b0, SIZE_WORD, 32'h040, '0);
    // Alias of the failed write stays unchanged
    send_req(1'b0, SIZE_WORD, 32'h110, '0);
    drain();
  endtask

  task automatic test_wait_order();
    for (int i = 0; i < 24; i++) begin
      send_random(2'(i));
    end
    drain();
  endtask

  task automatic test_backpressure();
    int base;
    int sent;
    base        = rsp_seen;
    sent        = 0;
    hold_credit = 1'b1;
    // Offer eight requests while the consumer keeps its credits
    for (int c = 0; c < 60; c++) begin
      if (credits > 0 && sent < 8) begin
        send_random(2'(c));
        sent++;
      end else begin
        tick();
      end
    end
    check_val("responses while credits held", 32'(rsp_seen - base), 32'(RSP_CREDITS));
    check_val("requests accepted while stalled", 32'(sent),
              32'(REQ_CREDITS + CMD_CREDITS + RSP_CREDITS));
    check_val("requester credits", 32'(credits), 32'd0);
    n_checks++;
    assert (cycle - last_credit_cycle >= 30) else begin
      n_errors++;
      $display("req_credit kept pulsing while responses were held back");
    end
    hold_credit = 1'b0;
    while (sent < 8) begin
      send_random(2'(sent));
      sent++;
    end
    drain();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hce4b7070));
    HCLK              = 1'b0;
    ahb_rstn          = 1'b0;
    req_valid         = 1'b0;
    req               = '0;
    rsp_credit        = 1'b0;
    hold_credit       = 1'b0;
    data_due          = 1'b0;
    data_chk          = '0;
    credits           = REQ_CREDITS;
    owed              = 0;
    cycle             = 0;
    last_rsp_cycle    = 0;
    last_credit_cycle = 0;
    rsp_seen          = 0;
    wr_seen           = 0;
    n_checks          = 0;
    n_errors          = 0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_byte(10'(i));
    end
    repeat (4) @(posedge HCLK);
    #1;
    ahb_rstn = 1'b1;
    test_reset();
    test_round_trip();
    test_write_lanes();
    test_bus_error();
    test_wait_order();
    test_backpressure();
    end_run();
  end

endmodule

// File: files.f
design/ahb_lite_pkg.sv
design/dbg_req_pkg.sv
design/dbg_req_stage.sv
design/ahb_issue_stage.sv
design/dbg_rsp_stage.sv
design/dbg_ahb_bridge.sv
sim/ahb_mem_model.sv
sim/tb_dbg_ahb_bridge.sv

// File: Makefile
TOP := tb_dbg_ahb_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only -Wall --top-module dbg_ahb_bridge \
	  design/ahb_lite_pkg.sv design/dbg_req_pkg.sv design/dbg_req_stage.sv \
	  design/ahb_issue_stage.sv design/dbg_rsp_stage.sv design/dbg_ahb_bridge.sv

clean:
	rm -rf obj_dir
